/* sources.f */
+incdir+source
source/mem_pkg.sv
source/mem_request_gen.sv
source/store_buffer.sv
source/load_formatter.sv
source/data_ram.sv
source/mem_stage.sv
verification/mem_stage_asserts.sv
verification/mem_stage_tb.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - include_dirs:
      - source
    files:
      - source/mem_pkg.sv
      - source/mem_request_gen.sv
      - source/store_buffer.sv
      - source/load_formatter.sv
      - source/data_ram.sv
      - source/mem_stage.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - verification/mem_stage_asserts.sv
      - verification/mem_stage_tb.sv

/* verification/mem_stage_tb.sv */
`timescale 1ns/1ns
`include "mem_stage_macros.svh"

module mem_stage_tb;

    typedef struct packed
    {
        mem_pkg::mem_op_t op;
        mem_pkg::word_t   addr;
        mem_pkg::word_t   data;
        logic [7:0]       count;
        logic [3:0]       step;
        logic [3:0]       flags;
        mem_pkg::word_t   exp;
    } row_t;

    localparam logic [3:0] flag_none     = 4'b0000;
    localparam logic [3:0] flag_chk      = 4'b0001;
    localparam logic [3:0] flag_ovf      = 4'b0010;
    localparam logic [3:0] flag_rnd_addr = 4'b0100;
    localparam logic [3:0] flag_rnd_data = 4'b1000;
    localparam int         num_rows      = 27;

    // Random rows pick offsets inside the window at 0x100.
    row_t table_rows [num_rows] = '{
        '{mem_pkg::op_sw,  32'h000, 32'h1234_5678, 8'd1,  4'd0, flag_none, 32'h0},
        '{mem_pkg::op_lw,  32'h000, 32'h0,         8'd1,  4'd0, flag_chk,  32'h1234_5678},
        '{mem_pkg::op_sw,  32'h020, 32'hdead_beef, 8'd4,  4'd4, flag_none, 32'h0},
        '{mem_pkg::op_lw,  32'h02c, 32'h0,         8'd1,  4'd0, flag_chk,  32'hdead_beef},
        '{mem_pkg::op_sw,  32'h040, 32'h0,         8'd1,  4'd0, flag_none, 32'h0},
        '{mem_pkg::op_sb,  32'h041, 32'h0000_00ab, 8'd1,  4'd0, flag_none, 32'h0},
        '{mem_pkg::op_sh,  32'h042, 32'h0000_beef, 8'd1,  4'd0, flag_none, 32'h0},
        '{mem_pkg::op_lw,  32'h040, 32'h0,         8'd1,  4'd0, flag_chk,  32'hbeef_ab00},
        '{mem_pkg::op_sb,  32'h040, 32'hffff_ff7e, 8'd1,  4'd0, flag_none, 32'h0},
        '{mem_pkg::op_lw,  32'h040, 32'h0,         8'd1,  4'd0, flag_chk,  32'hbeef_ab7e},
        '{mem_pkg::op_sw,  32'h080, 32'h8070_f00f, 8'd1,  4'd0, flag_none, 32'h0},
        '{mem_pkg::op_lb,  32'h081, 32'h0,         8'd1,  4'd0, flag_chk,  32'hffff_fff0},
        '{mem_pkg::op_lbu, 32'h081, 32'h0,         8'd1,  4'd0, flag_chk,  32'h0000_00f0},
        '{mem_pkg::op_lh,  32'h082, 32'h0,         8'd1,  4'd0, flag_chk,  32'hffff_8070},
        '{mem_pkg::op_lhu, 32'h082, 32'h0,         8'd1,  4'd0, flag_chk,  32'h0000_8070},
        '{mem_pkg::op_lb,  32'h080, 32'h0,         8'd4,  4'd1, flag_none, 32'h0},
        '{mem_pkg::op_sw,  32'h100, 32'h0,         8'd16, 4'd4, flag_ovf | flag_rnd_data, 32'h0},
        '{mem_pkg::op_lb,  32'h100, 32'h0,         8'd64, 4'd1, flag_none, 32'h0},
        '{mem_pkg::op_lbu, 32'h100, 32'h0,         8'd64, 4'd1, flag_none, 32'h0},
        '{mem_pkg::op_lh,  32'h100, 32'h0,         8'd32, 4'd2, flag_none, 32'h0},
        '{mem_pkg::op_lhu, 32'h100, 32'h0,         8'd32, 4'd2, flag_none, 32'h0},
        '{mem_pkg::op_sb,  32'h100, 32'h0,         8'd6,  4'd0, flag_rnd_addr | flag_rnd_data, 32'h0},
        '{mem_pkg::op_lw,  32'h100, 32'h0,         8'd16, 4'd4, flag_none, 32'h0},
        '{mem_pkg::op_sh,  32'h100, 32'h0,         8'd6,  4'd0, flag_rnd_addr | flag_rnd_data, 32'h0},
        '{mem_pkg::op_lh,  32'h100, 32'h0,         8'd8,  4'd0, flag_rnd_addr, 32'h0},
        '{mem_pkg::op_sw,  32'h200, 32'h0,         8'(2 * `SBUFFER_SIZE), 4'd4,
          flag_ovf | flag_rnd_data, 32'h0},
        '{mem_pkg::op_lw,  32'h200, 32'h0,         8'(2 * `SBUFFER_SIZE), 4'd4, flag_none, 32'h0}
    };

    logic             clk;
    logic             reset;
    logic             req_en;
    mem_pkg::mem_op_t op;
    mem_pkg::word_t   addr;
    mem_pkg::word_t   store_data;
    mem_pkg::word_t   load_data;
    logic             finish;
    logic             overflow;
    logic [7:0]       ref_mem [1024];
    integer           seed;
    int               errors;
    int               checks;

    mem_stage dut_i
    (
        .clk        (clk),
        .reset      (reset),
        .req_en     (req_en),
        .op         (op),
        .addr       (addr),
        .store_data (store_data),
        .load_data  (load_data),
        .finish     (finish),
        .overflow   (overflow)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    function automatic logic is_store(input mem_pkg::mem_op_t o);
        return o == mem_pkg::op_sb || o == mem_pkg::op_sh || o == mem_pkg::op_sw;
    endfunction

    // Offset in the 64-byte window, aligned to the access size.
    function automatic mem_pkg::word_t window_offset(input mem_pkg::mem_op_t o,
                                                     input mem_pkg::word_t r);
        case (o)
            mem_pkg::op_lb, mem_pkg::op_lbu, mem_pkg::op_sb: return r & 32'h3f;
            mem_pkg::op_lh, mem_pkg::op_lhu, mem_pkg::op_sh: return r & 32'h3e;
            default: return r & 32'h3c;
        endcase
    endfunction

    // Little-endian byte image of the RAM.
    task automatic store_ref(input mem_pkg::mem_op_t o, input mem_pkg::word_t a,
                             input mem_pkg::word_t d);
        logic [9:0] i;
        i = a[9:0];
        case (o)
            mem_pkg::op_sb:
                ref_mem[i] = d[7:0];
            mem_pkg::op_sh:
            begin
                ref_mem[{i[9:1], 1'b0}] = d[7:0];
                ref_mem[{i[9:1], 1'b1}] = d[15:8];
            end
            default:
                for (int k = 0; k < 4; k++)
                begin
                    ref_mem[{i[9:2], 2'(k)}] = d[8*k +: 8];
                end
        endcase
    endtask

    function automatic mem_pkg::word_t expected_load(input mem_pkg::mem_op_t o,
                                                     input mem_pkg::word_t a);
        logic [9:0]  i;
        logic [7:0]  b;
        logic [15:0] h;
        i = a[9:0];
        b = ref_mem[i];
        h = {ref_mem[{i[9:1], 1'b1}], ref_mem[{i[9:1], 1'b0}]};
        case (o)
            mem_pkg::op_lb:  return {{24{b[7]}}, b};
            mem_pkg::op_lbu: return {24'b0, b};
            mem_pkg::op_lh:  return {{16{h[15]}}, h};
            mem_pkg::op_lhu: return {16'b0, h};
            default:
                return {ref_mem[{i[9:2], 2'd3}], ref_mem[{i[9:2], 2'd2}],
                        ref_mem[{i[9:2], 2'd1}], ref_mem[{i[9:2], 2'd0}]};
        endcase
    endfunction

    task automatic check_value(input mem_pkg::word_t got, input mem_pkg::word_t exp,
                               input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Present one operation and hold it until finish.
    task automatic run_op(input mem_pkg::mem_op_t o, input mem_pkg::word_t a,
                          input mem_pkg::word_t d, output mem_pkg::word_t got,
                          output logic ovf_hit);
        @(posedge clk);
        #1;
        req_en     = 1'b1;
        op         = o;
        addr       = a;
        store_data = d;
        ovf_hit    = 1'b0;
        do
        begin
            @(negedge clk);
            ovf_hit = ovf_hit | overflow;
            if (overflow)
            begin
                check_value(32'(finish), 32'd0, "finish during overflow");
            end
        end
        while (!finish);
        got = load_data;
    endtask

    initial
    begin
        mem_pkg::word_t a;
        mem_pkg::word_t d;
        mem_pkg::word_t got;
        logic           hit;
        logic           row_ovf;
        seed       = 32'h61be;
        errors     = 0;
        checks     = 0;
        reset      = 1'b1;
        req_en     = 1'b0;
        op         = mem_pkg::op_lw;
        addr       = '0;
        store_data = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_value(32'(finish), 32'd1, "finish while idle");
        check_value(32'(overflow), 32'd0, "overflow while idle");
        for (int r = 0; r < num_rows; r++)
        begin
            row_ovf = 1'b0;
            for (int n = 0; n < int'(table_rows[r].count); n++)
            begin
                a = table_rows[r].addr + 32'(n) * 32'(table_rows[r].step);
                d = table_rows[r].data;
                if ((table_rows[r].flags & flag_rnd_addr) != 0)
                begin
                    a = table_rows[r].addr + window_offset(table_rows[r].op, $random(seed));
                end
                if ((table_rows[r].flags & flag_rnd_data) != 0)
                begin
                    d = $random(seed);
                end
                run_op(table_rows[r].op, a, d, got, hit);
                row_ovf = row_ovf | hit;
                if (is_store(table_rows[r].op))
                begin
                    store_ref(table_rows[r].op, a, d);
                end
                else
                begin
                    check_value(got, expected_load(table_rows[r].op, a),
                                $sformatf("row %0d load at %h", r, a));
                    if ((table_rows[r].flags & flag_chk) != 0)
                    begin
                        check_value(got, table_rows[r].exp, $sformatf("row %0d table value", r));
                    end
                end
            end
            check_value(32'(row_ovf), 32'((table_rows[r].flags & flag_ovf) != 0),
                        $sformatf("row %0d overflow seen", r));
        end
        @(posedge clk);
        #1;
        req_en = 1'b0;
        @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Worst case per operation is a full buffer drain.
    initial
    begin
        longint ops;
        ops = 4;
        for (int r = 0; r < num_rows; r++)
        begin
            ops += table_rows[r].count;
        end
        #(ops * (`SBUFFER_SIZE + 1) * (`MEM_WAIT_CYCLES + 2) * 10);
        $display("Timeout: the operations did not all finish in the expected time");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* verification/mem_stage_asserts.sv */
`timescale 1ns/1ns
`include "mem_stage_macros.svh"

module mem_stage_asserts
(
    input logic                     clk,
    input logic                     reset,
    input logic                     overflow,
    input logic                     finish,
    input logic                     dmem_en,
    input logic                     dmem_wt,
    input mem_pkg::word_t           dmem_addr,
    input mem_pkg::word_t           dmem_wd,
    input mem_pkg::mem_size_t       dmem_size,
    input logic                     data_ok,
    input logic [`SBUFFER_SIZE-1:0] valid
);

    // Overflow only with every slot taken.
    overflow_when_full: assert property
    (
        @(posedge clk) disable iff (reset)
        overflow |-> &valid
    )
    else $error("Overflow raised while the store buffer has a free slot");

    // Port content may change only after the RAM completes.
    port_stable: assert property
    (
        @(posedge clk) disable iff (reset)
        (dmem_en && !data_ok) |=> $stable({dmem_en, dmem_wt, dmem_addr, dmem_wd, dmem_size})
    )
    else $error("Memory port changed before data_ok");

    // A stalled store goes in right after the head retires.
    accept_after_drain: assert property
    (
        @(posedge clk) disable iff (reset)
        (overflow && data_ok) |=> (finish && !overflow)
    )
    else $error("Stalled store not accepted in the cycle after the head drained");

endmodule

bind store_buffer mem_stage_asserts sbuf_asserts_i
(
    .clk       (clk),
    .reset     (reset),
    .overflow  (overflow),
    .finish    (finish),
    .dmem_en   (dmem_en),
    .dmem_wt   (dmem_wt),
    .dmem_addr (dmem_addr),
    .dmem_wd   (dmem_wd),
    .dmem_size (dmem_size),
    .data_ok   (data_ok),
    .valid     (valid)
);

/* source/mem_stage.sv */
`timescale 1ns/1ns

module mem_stage
(
    input  logic             clk,
    input  logic             reset,
    input  logic             req_en,
    input  mem_pkg::mem_op_t op,
    input  mem_pkg::word_t   addr,
    input  mem_pkg::word_t   store_data,
    output mem_pkg::word_t   load_data,
    output logic             finish,
    output logic             overflow
);

    mem_pkg::mem_req_t  req;
    mem_pkg::mem_req_t  load_req;
    mem_pkg::word_t     rd_word;
    logic               dmem_en;
    logic               dmem_wt;
    mem_pkg::word_t     dmem_addr;
    mem_pkg::word_t     dmem_wd;
    mem_pkg::mem_size_t dmem_size;
    mem_pkg::word_t     dmem_rd;
    logic               data_ok;

    mem_request_gen req_gen_i
    (
        .req_en     (req_en),
        .op         (op),
        .addr       (addr),
        .store_data (store_data),
        .req        (req)
    );

    store_buffer sbuf_i
    (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .dmem_rd   (dmem_rd),
        .data_ok   (data_ok),
        .overflow  (overflow),
        .finish    (finish),
        .dmem_en   (dmem_en),
        .dmem_wt   (dmem_wt),
        .dmem_addr (dmem_addr),
        .dmem_wd   (dmem_wd),
        .dmem_size (dmem_size),
        .rd_word   (rd_word),
        .load_req  (load_req)
    );

    load_formatter fmt_i
    (
        .rd_word   (rd_word),
        .load_req  (load_req),
        .load_data (load_data)
    );

    data_ram ram_i
    (
        .clk       (clk),
        .reset     (reset),
        .dmem_en   (dmem_en),
        .dmem_wt   (dmem_wt),
        .dmem_addr (dmem_addr),
        .dmem_wd   (dmem_wd),
        .dmem_size (dmem_size),
        .dmem_rd   (dmem_rd),
        .data_ok   (data_ok)
    );

endmodule

/* source/data_ram.sv */
`timescale 1ns/1ns
`include "mem_stage_macros.svh"

module data_ram
(
    input  logic               clk,
    input  logic               reset,
    input  logic               dmem_en,
    input  logic               dmem_wt,
    input  mem_pkg::word_t     dmem_addr,
    input  mem_pkg::word_t     dmem_wd,
    input  mem_pkg::mem_size_t dmem_size,
    output mem_pkg::word_t     dmem_rd,
    output logic               data_ok
);

    localparam int INDEX_BITS = $clog2(`RAM_WORDS);
    localparam int WAIT_BITS  = $clog2(`MEM_WAIT_CYCLES + 1);

    logic [3:0][7:0]       mem [`RAM_WORDS];
    logic [INDEX_BITS-1:0] index;
    logic [WAIT_BITS-1:0]  wait_cnt;
    logic [3:0]            lane_en;

    assign index = dmem_addr[INDEX_BITS+1:2];

    // Count while the port is held, restart after each completion.
    always_ff @(posedge clk)
    begin
        if (reset || !dmem_en || data_ok)
        begin
            wait_cnt <= '0;
        end
        else
        begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    assign data_ok = dmem_en && (wait_cnt == WAIT_BITS'(`MEM_WAIT_CYCLES));

    always_comb
    begin
        case (dmem_size)
            mem_pkg::size_byte: lane_en = 4'b0001 << dmem_addr[1:0];
            mem_pkg::size_half: lane_en = dmem_addr[1] ? 4'b1100 : 4'b0011;
            default:            lane_en = 4'b1111;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (data_ok && dmem_wt)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (lane_en[i])
                begin
                    mem[index][i] <= dmem_wd[8*i +: 8];
                end
            end
        end
    end

    assign dmem_rd = (data_ok && !dmem_wt) ? mem[index] : '0;

endmodule

/* source/load_formatter.sv */
`timescale 1ns/1ns

module load_formatter
(
    input  mem_pkg::word_t    rd_word,
    input  mem_pkg::mem_req_t load_req,
    output mem_pkg::word_t    load_data
);

    mem_pkg::read_word_u rw;
    logic [7:0]          sel_byte;
    logic [15:0]         sel_half;

    assign rw = rd_word;

    // Byte by the full offset, halfword by bit one.
    assign sel_byte = rw.b[load_req.addr[1:0]];
    assign sel_half = rw.h[load_req.addr[1]];

    always_comb
    begin
        case (load_req.op)
            mem_pkg::op_lb:
            begin
                load_data = {{24{sel_byte[7]}}, sel_byte};
            end
            mem_pkg::op_lbu:
            begin
                load_data = {24'b0, sel_byte};
            end
            mem_pkg::op_lh:
            begin
                load_data = {{16{sel_half[15]}}, sel_half};
            end
            mem_pkg::op_lhu:
            begin
                load_data = {16'b0, sel_half};
            end
            mem_pkg::op_lw:
            begin
                load_data = rw.w;
            end
            default:
            begin
                // Stores return nothing.
                load_data = '0;
            end
        endcase
    end

endmodule

/* source/store_buffer.sv */
`timescale 1ns/1ns
`include "mem_stage_macros.svh"

module store_buffer
(
    input  logic               clk,
    input  logic               reset,
    input  mem_pkg::mem_req_t  req,
    input  mem_pkg::word_t     dmem_rd,
    input  logic               data_ok,
    output logic               overflow,
    output logic               finish,
    output logic               dmem_en,
    output logic               dmem_wt,
    output mem_pkg::word_t     dmem_addr,
    output mem_pkg::word_t     dmem_wd,
    output mem_pkg::mem_size_t dmem_size,
    output mem_pkg::word_t     rd_word,
    output mem_pkg::mem_req_t  load_req
);

    mem_pkg::mem_req_t [`SBUFFER_SIZE-1:0] buffer;
    logic [`SBUFFER_SIZE-1:0]              valid;
    logic [`SBUFFER_WIDTH-1:0]             head;
    logic [`SBUFFER_WIDTH-1:0]             tail;
    logic [`SBUFFER_WIDTH-1:0]             head_next;
    logic [`SBUFFER_WIDTH-1:0]             tail_next;
    logic                                  store_req;
    logic                                  load_req_en;
    logic                                  push;
    logic                                  retire;
    mem_pkg::mem_req_t                     port;

    // Pointers wrap since the depth is a power of two.
    assign head_next = head + 1'b1;
    assign tail_next = tail + 1'b1;

    assign store_req   = req.en && req.wt;
    assign load_req_en = req.en && !req.wt;

    // Tail slot still occupied means the queue is full.
    assign overflow = store_req && valid[tail];
    assign push     = store_req && !valid[tail];
    assign retire   = data_ok && valid[head];

    // Load completes only once the queue has drained.
    assign finish = !req.en
                 || push
                 || (load_req_en && !valid[head] && data_ok);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            head  <= '0;
            tail  <= '0;
            valid <= '0;
        end
        else
        begin
            if (retire)
            begin
                valid[head] <= 1'b0;
                head        <= head_next;
            end
            if (push)
            begin
                valid[tail] <= 1'b1;
                tail        <= tail_next;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            buffer[tail] <= req;
        end
    end

    // Queued stores own the port; a load goes out only behind them.
    always_comb
    begin
        if (valid[head])
        begin
            port = buffer[head];
        end
        else if (load_req_en)
        begin
            port = req;
        end
        else
        begin
            port = '0;
        end
    end

    assign dmem_en   = port.en;
    assign dmem_wt   = port.wt;
    assign dmem_addr = port.addr;
    assign dmem_wd   = port.wd;
    assign dmem_size = port.size;

    assign rd_word  = dmem_rd;
    assign load_req = port;

endmodule

/* source/mem_request_gen.sv */
`timescale 1ns/1ns

module mem_request_gen
(
    input  logic              req_en,
    input  mem_pkg::mem_op_t  op,
    input  mem_pkg::word_t    addr,
    input  mem_pkg::word_t    store_data,
    output mem_pkg::mem_req_t req
);

    logic               is_store;
    mem_pkg::mem_size_t size;
    mem_pkg::word_t     lane_data;

    // Stores sit at the top of the encoding.
    always_comb
    begin
        case (op)
            mem_pkg::op_sb,
            mem_pkg::op_sh,
            mem_pkg::op_sw:
                is_store = 1'b1;
            default:
                is_store = 1'b0;
        endcase
    end

    always_comb
    begin
        case (op)
            mem_pkg::op_lb,
            mem_pkg::op_lbu,
            mem_pkg::op_sb:
                size = mem_pkg::size_byte;
            mem_pkg::op_lh,
            mem_pkg::op_lhu,
            mem_pkg::op_sh:
                size = mem_pkg::size_half;
            default:
                size = mem_pkg::size_word;
        endcase
    end

    // Copy the byte or halfword onto every lane; byte enables pick one.
    always_comb
    begin
        if (!is_store)
        begin
            lane_data = '0;
        end
        else
        begin
            case (size)
                mem_pkg::size_byte:
                    lane_data = {4{store_data[7:0]}};
                mem_pkg::size_half:
                    lane_data = {2{store_data[15:0]}};
                default:
                    lane_data = store_data;
            endcase
        end
    end

    always_comb
    begin
        req.en   = req_en;
        req.wt   = is_store;
        req.addr = addr;
        req.wd   = lane_data;
        req.size = size;
        req.op   = op;
    end

endmodule

/* source/mem_pkg.sv */
package mem_pkg;

    typedef logic [31:0] word_t;

    // Loads first, stores last.
    typedef enum logic [2:0]
    {
        op_lb  = 3'd0,
        op_lbu = 3'd1,
        op_lh  = 3'd2,
        op_lhu = 3'd3,
        op_lw  = 3'd4,
        op_sb  = 3'd5,
        op_sh  = 3'd6,
        op_sw  = 3'd7
    } mem_op_t;

    typedef enum logic [1:0]
    {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_t;

    // One memory request as it travels through the stage.
    typedef struct packed
    {
        logic      en;
        logic      wt;
        word_t     addr;
        word_t     wd;     // Lane-aligned store data.
        mem_size_t size;
        mem_op_t   op;
    } mem_req_t;

    // Returned word, seen as bytes or as halfwords.
    typedef union packed
    {
        word_t                w;
        logic [3:0][7:0]      b;
        logic [1:0][15:0]     h;
    } read_word_u;

endpackage

/* source/mem_stage_macros.svh */
`ifndef MEM_STAGE_MACROS_SVH
`define MEM_STAGE_MACROS_SVH

// Store buffer depth and its pointer width.
`define SBUFFER_SIZE 8
`define SBUFFER_WIDTH 3

// Data RAM depth in 32-bit words.
`define RAM_WORDS 256

// Cycles the RAM waits before data_ok.
`define MEM_WAIT_CYCLES 2

`endif
